// File: Makefile
# Verilator build and run for the iterative divider testbench

TOP := int_div_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: all.f
rtl/imuldiv_msg_pkg.sv
rtl/imuldiv_ctrl_pkg.sv
rtl/int_div_dpath.sv
rtl/int_div_ctrl.sv
rtl/int_div_iterative.sv
testbench/int_div_checker.sv
testbench/int_div_tb.sv

// File: rtl/imuldiv_ctrl_pkg.sv
// divider control definitions
// FSM states and the step counter

package imuldiv_ctrl_pkg;

  // shift-subtract iterations per division
  localparam int DIV_STEPS = 32;

  // counter holds 0 .. DIV_STEPS with room to spare
  localparam int STEP_CNT_W = 6;

  typedef logic [STEP_CNT_W-1:0] step_count_t;

  // idle -> calc on request, calc -> done after the last step
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CALC,
    ST_DONE
  } div_state_t;

endpackage

// File: rtl/imuldiv_msg_pkg.sv
// divider message definitions
// operand width, function codes and response layout

package imuldiv_msg_pkg;

  // ------------------------------
  // widths
  // ------------------------------

  // operand, quotient and remainder width
  localparam int OPERAND_W = 32;

  // response carries remainder and quotient side by side
  localparam int RESULT_W = 2 * OPERAND_W;

  // ------------------------------
  // function codes
  // ------------------------------

  // one bit on the request, picks the operand interpretation
  localparam logic FN_UNSIGNED = 1'b0;
  localparam logic FN_SIGNED   = 1'b1;

  // ------------------------------
  // message types
  // ------------------------------

  typedef logic [OPERAND_W-1:0] operand_t;

  // bits 63..32 hold the remainder, bits 31..0 the quotient
  typedef logic [RESULT_W-1:0] result_t;

endpackage

// File: rtl/int_div_ctrl.sv
// iterative divider control
// FSM, step counter and valid/ready handshake

`timescale 1ns/1ps

module int_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic load,
  output logic step
);

  import imuldiv_ctrl_pkg::*;

  div_state_t  state;
  div_state_t  state_next;
  step_count_t step_cnt;
  logic        last_step;
  logic        resp_fire;

  // ------------------------------
  // handshake outputs
  // ------------------------------

  // one division at a time, accept only when idle
  assign req_rdy  = (state == ST_IDLE);
  assign resp_val = (state == ST_DONE);

  // load on the request handshake cycle
  assign load = req_val && req_rdy;

  // one shift-subtract per calc cycle
  assign step = (state == ST_CALC);

  assign resp_fire = resp_val && resp_rdy;

  // ------------------------------
  // step counter
  // ------------------------------

  // 32nd step happens when the count reads DIV_STEPS-1
  assign last_step = (step_cnt == step_count_t'(DIV_STEPS - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      step_cnt <= '0;
    end else if (load) begin
      step_cnt <= '0;
    end else if (step) begin
      step_cnt <= step_cnt + 1'b1;
    end
  end

  // ------------------------------
  // state machine
  // ------------------------------

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (load) begin
          state_next = ST_CALC;
        end
      end
      ST_CALC: begin
        // done is entered on the edge of the final step
        if (last_step) begin
          state_next = ST_DONE;
        end
      end
      ST_DONE: begin
        // hold result until the consumer takes it
        if (resp_fire) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

endmodule

// File: rtl/int_div_dpath.sv
// iterative divider datapath
// restoring shift-subtract loop with sign handling on load and on output

`timescale 1ns/1ps

module int_div_dpath (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     load,
  input  logic                     step,
  input  logic                     req_fn,
  input  imuldiv_msg_pkg::operand_t req_a,
  input  imuldiv_msg_pkg::operand_t req_b,
  output imuldiv_msg_pkg::result_t  resp_result
);

  import imuldiv_msg_pkg::*;

  // ------------------------------
  // registers
  // ------------------------------

  // upper 33 bits partial remainder, lower 32 bits dividend / quotient
  logic [2*OPERAND_W:0] rq_reg;
  operand_t             divisor_reg;

  // request attributes kept for the final fix-up
  logic fn_reg;
  logic sign_a_reg;
  logic sign_b_reg;

  // ------------------------------
  // load path
  // ------------------------------

  logic     a_neg;
  logic     b_neg;
  operand_t a_mag;
  operand_t b_mag;

  // only signed requests treat the top bit as a sign
  assign a_neg = (req_fn == FN_SIGNED) && req_a[OPERAND_W-1];
  assign b_neg = (req_fn == FN_SIGNED) && req_b[OPERAND_W-1];

  // two's complement magnitude
  assign a_mag = a_neg ? (~req_a + 1'b1) : req_a;
  assign b_mag = b_neg ? (~req_b + 1'b1) : req_b;

  // ------------------------------
  // step logic
  // ------------------------------

  logic [2*OPERAND_W:0] rq_shift;
  logic [OPERAND_W:0]   diff;
  logic                 diff_neg;

  assign rq_shift = {rq_reg[2*OPERAND_W-1:0], 1'b0};

  // trial subtract against the upper part
  assign diff     = rq_shift[2*OPERAND_W:OPERAND_W] - {1'b0, divisor_reg};
  assign diff_neg = diff[OPERAND_W];

  // shift-subtract register and divisor
  always_ff @(posedge clk) begin
    if (load) begin
      rq_reg      <= {{(OPERAND_W+1){1'b0}}, a_mag};
      divisor_reg <= b_mag;
    end else if (step) begin
      if (diff_neg) begin
        // restore and leave the quotient bit at zero
        rq_reg <= rq_shift;
      end else begin
        // keep difference and set quotient bit
        rq_reg <= {diff, rq_shift[OPERAND_W-1:1], 1'b1};
      end
    end
  end

  // sign and function flags
  always_ff @(posedge clk) begin
    if (reset) begin
      fn_reg     <= FN_UNSIGNED;
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
    end else if (load) begin
      fn_reg     <= req_fn;
      sign_a_reg <= req_a[OPERAND_W-1];
      sign_b_reg <= req_b[OPERAND_W-1];
    end
  end

  // ------------------------------
  // result fix-up
  // ------------------------------

  operand_t quot_mag;
  operand_t rem_mag;
  operand_t quot;
  operand_t rem;
  logic     quot_neg;
  logic     rem_neg;

  // remainder always fits below the divisor, so bit 64 is dropped
  assign quot_mag = rq_reg[OPERAND_W-1:0];
  assign rem_mag  = rq_reg[2*OPERAND_W-1:OPERAND_W];

  // quotient negative when exactly one operand is negative
  assign quot_neg = (fn_reg == FN_SIGNED) && (sign_a_reg ^ sign_b_reg);
  // remainder follows the dividend
  assign rem_neg  = (fn_reg == FN_SIGNED) && sign_a_reg;

  assign quot = quot_neg ? (~quot_mag + 1'b1) : quot_mag;
  assign rem  = rem_neg ? (~rem_mag + 1'b1) : rem_mag;

  // combinational and valid while the FSM sits in done
  assign resp_result = {rem, quot};

endmodule

// File: rtl/int_div_iterative.sv
// iterative 32-bit integer divider
// valid/ready request and response, 32 steps per division

`timescale 1ns/1ps

module int_div_iterative (
  input  logic                      clk,
  input  logic                      reset,

  // request side
  input  logic                      req_fn,
  input  imuldiv_msg_pkg::operand_t req_a,
  input  imuldiv_msg_pkg::operand_t req_b,
  input  logic                      req_val,
  output logic                      req_rdy,

  // response side, {remainder, quotient}
  output imuldiv_msg_pkg::result_t  resp_result,
  output logic                      resp_val,
  input  logic                      resp_rdy
);

  // control to datapath
  logic load;
  logic step;

  int_div_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .load     (load),
    .step     (step)
  );

  // operands captured on load, result read out in done
  int_div_dpath u_dpath (
    .clk         (clk),
    .reset       (reset),
    .load        (load),
    .step        (step),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_result (resp_result)
  );

endmodule

// File: testbench/int_div_checker.sv
// handshake assertions for the iterative divider
// bound into the divider top level

`timescale 1ns/1ps

module int_div_checker (
  input logic                         clk,
  input logic                         reset,
  input logic                         req_rdy,
  input logic                         resp_val,
  input logic                         resp_rdy,
  input imuldiv_msg_pkg::result_t     resp_result,
  input imuldiv_ctrl_pkg::div_state_t state
);

  import imuldiv_ctrl_pkg::*;

  // assertion failures so far
  int fail_count = 0;

  // ------------------------------
  // handshake rules
  // ------------------------------

  // never ready for a request while a result waits
  rdy_val_exclusive: assert property (
    @(posedge clk) disable iff (reset) !(req_rdy && resp_val)
  ) else begin
    $error("req_rdy and resp_val high in the same cycle");
    fail_count++;
  end

  // stalled response holds valid and data
  resp_held_on_stall: assert property (
    @(posedge clk) disable iff (reset)
      (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result))
  ) else begin
    $error("response changed or dropped while resp_rdy was low");
    fail_count++;
  end

  // idle right after reset
  idle_after_reset: assert property (
    @(posedge clk) reset |=> (state == ST_IDLE && req_rdy && !resp_val)
  ) else begin
    $error("unit not idle in the cycle after reset");
    fail_count++;
  end

endmodule

// File: testbench/int_div_tb.sv
// testbench for the iterative divider
// table of fixed and random requests, stalls on the response side

`timescale 1ns/1ps

module int_div_tb;

  import imuldiv_msg_pkg::*;

  // ------------------------------
  // sizes and timing
  // ------------------------------

  localparam int NUM_FIXED    = 15;
  localparam int NUM_RANDOM   = 16;
  localparam int NUM_TESTS    = NUM_FIXED + NUM_RANDOM;
  // rising edges from the one taking the request to the one raising resp_val
  localparam int EXP_LATENCY  = 33;
  localparam int RESET_CYCLES = 10;

  logic     clk;
  logic     reset;
  logic     req_fn;
  operand_t req_a;
  operand_t req_b;
  logic     req_val;
  logic     req_rdy;
  result_t  resp_result;
  logic     resp_val;
  logic     resp_rdy;

  // stimulus table with expected values
  logic     tbl_fn    [NUM_TESTS];
  operand_t tbl_a     [NUM_TESTS];
  operand_t tbl_b     [NUM_TESTS];
  operand_t tbl_quot  [NUM_TESTS];
  operand_t tbl_rem   [NUM_TESTS];
  int       tbl_stall [NUM_TESTS];

  integer seed;
  int     error_count   = 0;
  int     tests_failed  = 0;
  int     cycle_count   = 0;
  int     timeout_limit = 0;
  int     max_stall     = 0;
  bit     test_ok;

  int_div_iterative u_int_div_iterative (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  bind int_div_iterative int_div_checker u_checker (
    .clk         (clk),
    .reset       (reset),
    .req_rdy     (req_rdy),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result),
    .state       (u_ctrl.state)
  );

  // ------------------------------
  // clock and timeout
  // ------------------------------

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      $display("run timed out after %0d cycles, the divider stopped answering", cycle_count);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ------------------------------
  // reference model and table
  // ------------------------------

  // magnitudes divided and then the signs applied
  task automatic reference_divide(input logic fn, input operand_t a, input operand_t b,
                                  output operand_t q, output operand_t r);
    logic     a_neg;
    logic     b_neg;
    operand_t a_mag;
    operand_t b_mag;
    operand_t q_mag;
    operand_t r_mag;
    a_neg = (fn == FN_SIGNED) && a[OPERAND_W-1];
    b_neg = (fn == FN_SIGNED) && b[OPERAND_W-1];
    a_mag = a_neg ? -a : a;
    b_mag = b_neg ? -b : b;
    // zero divisor gives all ones and the dividend magnitude
    if (b_mag == '0) begin
      q_mag = '1;
      r_mag = a_mag;
    end else begin
      q_mag = a_mag / b_mag;
      r_mag = a_mag % b_mag;
    end
    q = (a_neg != b_neg) ? -q_mag : q_mag;
    r = a_neg ? -r_mag : r_mag;
  endtask

  task automatic add_entry(input int idx, input logic fn, input operand_t a,
                           input operand_t b, input operand_t q, input operand_t r,
                           input int stall);
    tbl_fn[idx]    = fn;
    tbl_a[idx]     = a;
    tbl_b[idx]     = b;
    tbl_quot[idx]  = q;
    tbl_rem[idx]   = r;
    tbl_stall[idx] = stall;
  endtask

  task automatic build_table();
    logic     fn;
    operand_t a;
    operand_t b;
    operand_t q;
    operand_t r;
    int       stall;
    // unsigned incl. a below b and a equal to b
    add_entry(0,  FN_UNSIGNED, 32'h00000064, 32'h00000007, 32'h0000000e, 32'h00000002, 0);
    add_entry(1,  FN_UNSIGNED, 32'h00000005, 32'h00000009, 32'h00000000, 32'h00000005, 2);
    add_entry(2,  FN_UNSIGNED, 32'h12345678, 32'h12345678, 32'h00000001, 32'h00000000, 0);
    add_entry(3,  FN_UNSIGNED, 32'hffffffff, 32'h00000001, 32'hffffffff, 32'h00000000, 1);
    add_entry(4,  FN_UNSIGNED, 32'hffffffff, 32'h00000010, 32'h0fffffff, 32'h0000000f, 3);
    // signed with all four sign pairs
    add_entry(5,  FN_SIGNED,   32'h00000007, 32'h00000002, 32'h00000003, 32'h00000001, 0);
    add_entry(6,  FN_SIGNED,   32'hfffffff9, 32'h00000002, 32'hfffffffd, 32'hffffffff, 0);
    add_entry(7,  FN_SIGNED,   32'h00000007, 32'hfffffffe, 32'hfffffffd, 32'h00000001, 1);
    add_entry(8,  FN_SIGNED,   32'hfffffff9, 32'hfffffffe, 32'h00000003, 32'hffffffff, 5);
    // most negative over minus one
    add_entry(9,  FN_SIGNED,   32'h80000000, 32'hffffffff, 32'h80000000, 32'h00000000, 0);
    // divide by zero
    add_entry(10, FN_UNSIGNED, 32'h00001234, 32'h00000000, 32'hffffffff, 32'h00001234, 0);
    add_entry(11, FN_SIGNED,   32'h00001234, 32'h00000000, 32'hffffffff, 32'h00001234, 2);
    add_entry(12, FN_SIGNED,   32'hfffffffb, 32'h00000000, 32'h00000001, 32'hfffffffb, 4);
    add_entry(13, FN_UNSIGNED, 32'h80000000, 32'hffffffff, 32'h00000000, 32'h80000000, 0);
    add_entry(14, FN_SIGNED,   32'h80000000, 32'h00000002, 32'hc0000000, 32'h00000000, 1);
    // random operands in both functions
    for (int i = 0; i < NUM_RANDOM; i++) begin
      fn = (i % 2 == 1) ? FN_SIGNED : FN_UNSIGNED;
      a  = $random(seed);
      b  = $random(seed);
      // shorter divisors give wider quotients
      b  = b >> ($unsigned($random(seed)) % OPERAND_W);
      stall = $unsigned($random(seed)) % 4;
      reference_divide(fn, a, b, q, r);
      add_entry(NUM_FIXED + i, fn, a, b, q, r, stall);
    end
  endtask

  // ------------------------------
  // compare tasks
  // ------------------------------

  task automatic compare_quotient(input int idx, input operand_t got, input operand_t exp);
    if (got !== exp) begin
      $display("mismatch test %0d resp_result[31:0] quotient: got 0x%08h expected 0x%08h",
               idx, got, exp);
      error_count++;
      test_ok = 1'b0;
    end
  endtask

  task automatic compare_remainder(input int idx, input operand_t got, input operand_t exp);
    if (got !== exp) begin
      $display("mismatch test %0d resp_result[63:32] remainder: got 0x%08h expected 0x%08h",
               idx, got, exp);
      error_count++;
      test_ok = 1'b0;
    end
  endtask

  task automatic compare_latency(input int idx, input int got, input int exp);
    if (got != exp) begin
      $display("mismatch test %0d resp_val latency: got 0x%0h cycles expected 0x%0h cycles",
               idx, got, exp);
      error_count++;
      test_ok = 1'b0;
    end
  endtask

  task automatic report_failure(input int idx, input string what);
    $display("test %0d failed: %s", idx, what);
    error_count++;
    test_ok = 1'b0;
  endtask

  function automatic string fn_name(input logic fn);
    return (fn == FN_SIGNED) ? "signed  " : "unsigned";
  endfunction

  // ------------------------------
  // one request and its response
  // ------------------------------

  task automatic run_test(input int idx);
    result_t first_result;
    int      latency;
    while (req_rdy !== 1'b1) begin
      @(negedge clk);
    end
    req_fn  = tbl_fn[idx];
    req_a   = tbl_a[idx];
    req_b   = tbl_b[idx];
    req_val = 1'b1;
    @(negedge clk);
    latency = 1;
    if (req_rdy !== 1'b0) begin
      report_failure(idx, "request was not taken while the unit was idle");
    end
    // operands and function must already be stored
    req_val = 1'b0;
    req_fn  = ~tbl_fn[idx];
    req_a   = ~tbl_a[idx];
    req_b   = ~tbl_b[idx];
    while (resp_val !== 1'b1) begin
      @(negedge clk);
      latency++;
    end
    compare_latency(idx, latency, EXP_LATENCY);
    first_result = resp_result;
    compare_quotient(idx, first_result[OPERAND_W-1:0], tbl_quot[idx]);
    compare_remainder(idx, first_result[2*OPERAND_W-1:OPERAND_W], tbl_rem[idx]);
    // result and ready held under back-pressure
    for (int s = 0; s < tbl_stall[idx]; s++) begin
      @(negedge clk);
      if (resp_val !== 1'b1) begin
        report_failure(idx, "resp_val dropped while resp_rdy was low");
      end
      if (req_rdy !== 1'b0) begin
        report_failure(idx, "req_rdy rose before the response handshake");
      end
      compare_quotient(idx, resp_result[OPERAND_W-1:0], tbl_quot[idx]);
      compare_remainder(idx, resp_result[2*OPERAND_W-1:OPERAND_W], tbl_rem[idx]);
    end
    resp_rdy = 1'b1;
    @(negedge clk);
    resp_rdy = 1'b0;
    if (resp_val !== 1'b0 || req_rdy !== 1'b1) begin
      report_failure(idx, "unit did not return to idle after the response handshake");
    end
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin
    int assert_fails;
    reset    = 1'b1;
    req_fn   = FN_UNSIGNED;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    seed     = 90780;
    build_table();
    for (int i = 0; i < NUM_TESTS; i++) begin
      if (tbl_stall[i] > max_stall) begin
        max_stall = tbl_stall[i];
      end
    end
    timeout_limit = NUM_TESTS * (40 + max_stall);
    repeat (RESET_CYCLES) begin
      @(negedge clk);
    end
    reset = 1'b0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      test_ok = 1'b1;
      run_test(i);
      if (!test_ok) begin
        tests_failed++;
      end
      $display("test %2d %s a=0x%08h b=0x%08h q=0x%08h r=0x%08h stall=%0d %s",
               i, fn_name(tbl_fn[i]), tbl_a[i], tbl_b[i], tbl_quot[i], tbl_rem[i],
               tbl_stall[i], test_ok ? "ok" : "error");
    end
    assert_fails = u_int_div_iterative.u_checker.fail_count;
    $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
             NUM_TESTS, tests_failed, error_count, assert_fails);
    if (tests_failed == 0 && error_count == 0 && assert_fails == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
